/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = load_cache_ctrl_tb
FILELIST  = src.f
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* hw/line_fill_buffer.sv */
// Line fill buffer holding the refill words from memory and counting arrivals for the allocator
`default_nettype none

`include "load_cache_params.svh"

module line_fill_buffer (
    input  wire                                           clk_i,
    input  wire                                           rst_n_i,

    // Refill words from memory
    input  load_cache_pkg::mem_word_t                     mem_word_i,

    // End of allocation, restart the count for the next refill
    input  wire                                           clear_i,

    output load_cache_pkg::word_t [`LC_BLOCK_WORDS-1:0]   line_words_o,
    output logic [$clog2(`LC_BLOCK_WORDS):0]              received_count_o
);

    // ----------------------------------------------------------
    // Word storage
    // ----------------------------------------------------------

    // The memory port is one word wide, so a line arrives over several cycles
    load_cache_pkg::word_t [`LC_BLOCK_WORDS-1:0] words_q;

    // Each word lands in the slot named by its one-hot marker
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `LC_BLOCK_WORDS; i++) begin
            if (mem_word_i.valid && mem_word_i.word[i]) begin
                words_q[i] <= mem_word_i.data;
            end
        end
    end

    // ----------------------------------------------------------
    // Arrival counter
    // ----------------------------------------------------------

    // One bit wider than the word select so a full line can be told apart from an empty one
    logic [$clog2(`LC_BLOCK_WORDS):0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (mem_word_i.valid) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign line_words_o     = words_q;
    assign received_count_o = count_q;

endmodule

`default_nettype wire

/* hw/load_cache_ctrl.sv */
// Top of the load cache controller joining the FSM, line fill buffer and victim LFSR
`default_nettype none

`include "load_cache_params.svh"

module load_cache_ctrl (
    input  wire                            clk_i,
    input  wire                            rst_n_i,

    // Load unit
    input  wire                            load_read_i,
    input  load_cache_pkg::load_addr_t     load_addr_i,

    // Store unit
    input  load_cache_pkg::load_addr_t     store_unit_addr_i,
    input  load_cache_pkg::word_t          store_unit_data_i,
    input  wire                            store_unit_idle_i,

    // Store buffer
    input  wire                            store_buffer_match_i,
    input  load_cache_pkg::word_t          store_buffer_data_i,

    // Cache arrays
    input  wire                            cache_hit_i,
    input  load_cache_pkg::word_t          cache_data_i,
    input  wire                            cache_grant_i,
    output load_cache_pkg::cache_read_t    cache_read_o,
    output load_cache_pkg::cache_write_t   cache_write_o,
    output load_cache_pkg::way_onehot_t    cache_way_o,
    output logic                           write_port_request_o,

    // Memory
    input  wire                            mem_ack_i,
    input  load_cache_pkg::mem_word_t      mem_word_i,
    output logic                           mem_request_o,

    // Pipeline and load result
    output logic                           stall_o,
    output load_cache_pkg::word_t          data_o,
    output logic                           data_valid_o,
    output logic                           done_o
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    load_cache_pkg::word_t [`LC_BLOCK_WORDS-1:0] line_words;
    logic [$clog2(`LC_BLOCK_WORDS):0]            received_count;
    logic                                        freeze;
    logic                                        fill_clear;

    line_fill_buffer fill0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .mem_word_i       (mem_word_i),
        .clear_i          (fill_clear),
        .line_words_o     (line_words),
        .received_count_o (received_count)
    );

    victim_way_lfsr lfsr0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .freeze_i (freeze),
        .way_o    (cache_way_o)
    );

    load_cache_fsm fsm0 (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .load_read_i          (load_read_i),
        .load_addr_i          (load_addr_i),
        .store_unit_addr_i    (store_unit_addr_i),
        .store_unit_data_i    (store_unit_data_i),
        .store_unit_idle_i    (store_unit_idle_i),
        .store_buffer_match_i (store_buffer_match_i),
        .store_buffer_data_i  (store_buffer_data_i),
        .cache_hit_i          (cache_hit_i),
        .cache_data_i         (cache_data_i),
        .cache_grant_i        (cache_grant_i),
        .mem_ack_i            (mem_ack_i),
        .line_words_i         (line_words),
        .received_count_i     (received_count),
        .cache_read_o         (cache_read_o),
        .cache_write_o        (cache_write_o),
        .mem_request_o        (mem_request_o),
        .write_port_request_o (write_port_request_o),
        .stall_o              (stall_o),
        .freeze_o             (freeze),
        .fill_clear_o         (fill_clear),
        .data_o               (data_o),
        .data_valid_o         (data_valid_o),
        .done_o               (done_o)
    );

endmodule

`default_nettype wire

/* hw/load_cache_fsm.sv */
// Load-side cache control FSM with forwarding, hit return and word-by-word refill allocation
`default_nettype none

`include "load_cache_params.svh"

module load_cache_fsm (
    input  wire                                          clk_i,
    input  wire                                          rst_n_i,

    // Load unit
    input  wire                                          load_read_i,
    input  load_cache_pkg::load_addr_t                   load_addr_i,

    // Store unit whose store in flight to the same address wins
    input  load_cache_pkg::load_addr_t                   store_unit_addr_i,
    input  load_cache_pkg::word_t                        store_unit_data_i,
    input  wire                                          store_unit_idle_i,

    // Store buffer with its address match done outside
    input  wire                                          store_buffer_match_i,
    input  load_cache_pkg::word_t                        store_buffer_data_i,

    // Cache arrays
    input  wire                                          cache_hit_i,
    input  load_cache_pkg::word_t                        cache_data_i,
    input  wire                                          cache_grant_i,

    // Memory and line fill buffer
    input  wire                                          mem_ack_i,
    input  load_cache_pkg::word_t [`LC_BLOCK_WORDS-1:0]  line_words_i,
    input  wire [$clog2(`LC_BLOCK_WORDS):0]              received_count_i,

    output load_cache_pkg::cache_read_t                  cache_read_o,
    output load_cache_pkg::cache_write_t                 cache_write_o,
    output logic                                         mem_request_o,
    output logic                                         write_port_request_o,
    output logic                                         stall_o,
    output logic                                         freeze_o,
    output logic                                         fill_clear_o,
    output load_cache_pkg::word_t                        data_o,
    output logic                                         data_valid_o,
    output logic                                         done_o
);

    localparam load_cache_pkg::word_sel_t last_word =
        load_cache_pkg::word_sel_t'(`LC_BLOCK_WORDS - 1);

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    load_cache_pkg::lc_state_t        state_q, state_d;
    load_cache_pkg::word_t            result_q, result_d;
    load_cache_pkg::word_sel_t        word_sel_q, word_sel_d;
    logic [$clog2(`LC_BLOCK_WORDS):0] alloc_cnt_q, alloc_cnt_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= load_cache_pkg::IDLE;
            word_sel_q  <= '0;
            alloc_cnt_q <= '0;
        end else begin
            state_q     <= state_d;
            word_sel_q  <= word_sel_d;
            alloc_cnt_q <= alloc_cnt_d;
        end
    end

    // The result register holds the forwarded or hit data shown on data_o in DATA_STABLE
    always_ff @(posedge clk_i) begin
        result_q <= result_d;
    end

    // ----------------------------------------------------------
    // Address and forwarding compare
    // ----------------------------------------------------------
    load_cache_pkg::cache_addr_t lookup_addr;
    load_cache_pkg::cache_addr_t alloc_addr;
    logic                        store_unit_match;

    assign lookup_addr = {load_addr_i.tag, load_addr_i.index, load_addr_i.word};

    // Allocation walks the line from word 0 and keeps tag and index of the load
    assign alloc_addr = {load_addr_i.tag, load_addr_i.index, word_sel_q};

    // An idle store unit carries a stale address and must not forward
    assign store_unit_match = (store_unit_addr_i == load_addr_i) && !store_unit_idle_i;

    // Victim way stays put from the memory request to the last write
    assign freeze_o = (state_q == load_cache_pkg::MEMORY_REQUEST) ||
                      (state_q == load_cache_pkg::ALLOCATE);

    // ----------------------------------------------------------
    // Next state and outputs
    // ----------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        result_d    = result_q;
        word_sel_d  = word_sel_q;
        alloc_cnt_d = alloc_cnt_q;

        cache_read_o       = '0;
        cache_read_o.addr  = lookup_addr;
        cache_write_o      = '0;
        cache_write_o.addr = alloc_addr;
        cache_write_o.data = line_words_i[word_sel_q];

        mem_request_o        = 1'b0;
        write_port_request_o = 1'b0;
        stall_o              = 1'b0;
        fill_clear_o         = 1'b0;
        data_o               = result_q;
        data_valid_o         = 1'b0;
        done_o               = 1'b0;

        unique case (state_q)
            load_cache_pkg::IDLE: begin
                if (load_read_i) begin
                    // Look up tag, status and data together in the request cycle
                    cache_read_o.read   = 1'b1;
                    cache_read_o.enable = '1;
                    state_d             = load_cache_pkg::COMPARE_TAG;

                    // Forwarding skips the hit check and the store unit goes first
                    if (store_unit_match) begin
                        result_d = store_unit_data_i;
                        state_d  = load_cache_pkg::DATA_STABLE;
                    end else if (store_buffer_match_i) begin
                        result_d = store_buffer_data_i;
                        state_d  = load_cache_pkg::DATA_STABLE;
                    end
                end
            end

            load_cache_pkg::COMPARE_TAG: begin
                // Cache answers the lookup in this cycle
                if (cache_hit_i) begin
                    result_d = cache_data_i;
                    state_d  = load_cache_pkg::DATA_STABLE;
                end else begin
                    stall_o = 1'b1;
                    state_d = load_cache_pkg::MEMORY_REQUEST;
                end
            end

            load_cache_pkg::DATA_STABLE: begin
                data_valid_o = 1'b1;
                done_o       = 1'b1;
                state_d      = load_cache_pkg::IDLE;
            end

            load_cache_pkg::MEMORY_REQUEST: begin
                mem_request_o = 1'b1;
                stall_o       = 1'b1;
                // Start the allocation from the first word of the line
                word_sel_d    = '0;
                alloc_cnt_d   = '0;
                if (mem_ack_i) begin
                    state_d = load_cache_pkg::ALLOCATE;
                end
            end

            load_cache_pkg::ALLOCATE: begin
                write_port_request_o = 1'b1;
                stall_o              = 1'b1;

                // Write only when granted and the next word is already in the fill buffer
                if (cache_grant_i && (alloc_cnt_q < received_count_i)) begin
                    cache_write_o.write = 1'b1;

                    // First write also sets tag, valid and clears dirty
                    if (word_sel_q == '0) begin
                        cache_write_o.enable = '1;
                    end else begin
                        cache_write_o.enable.data = 1'b1;
                    end

                    // The requested word goes to the load unit as it passes
                    data_o       = line_words_i[word_sel_q];
                    data_valid_o = (word_sel_q == load_addr_i.word);

                    word_sel_d  = word_sel_q + 1'b1;
                    alloc_cnt_d = alloc_cnt_q + 1'b1;

                    if (word_sel_q == last_word) begin
                        done_o       = 1'b1;
                        fill_clear_o = 1'b1;
                        state_d      = load_cache_pkg::IDLE;
                    end
                end
            end

            default: begin
                state_d = load_cache_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/load_cache_params.svh */
// Sizing macros for the load cache controller, included by the package and the modules that size ports
`ifndef LOAD_CACHE_PARAMS_SVH
`define LOAD_CACHE_PARAMS_SVH

// ----------------------------------------------------------
// Data path
// ----------------------------------------------------------

// Width of one data word on every port
`define LC_PORT_WIDTH 32

// Words per cache line, refilled one at a time
`define LC_BLOCK_WORDS 4

// Associativity of the cache, one-hot way select width
`define LC_WAYS 4

// ----------------------------------------------------------
// Address split, tag + index + word + byte offset is 32
// ----------------------------------------------------------
`define LC_TAG_BITS 22
`define LC_INDEX_BITS 6
`define LC_WORD_BITS 2
`define LC_OFFSET_BITS 2

`endif

/* hw/load_cache_pkg.sv */
// Shared types for the load cache controller, referenced by scoped name from every module
`default_nettype none

`include "load_cache_params.svh"

package load_cache_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`LC_PORT_WIDTH-1:0]  word_t;
    typedef logic [`LC_WORD_BITS-1:0]   word_sel_t;
    typedef logic [`LC_BLOCK_WORDS-1:0] word_onehot_t;
    typedef logic [`LC_WAYS-1:0]        way_onehot_t;

    // Full byte address of a load, as issued by the load unit
    typedef struct packed {
        logic [`LC_TAG_BITS-1:0]    tag;
        logic [`LC_INDEX_BITS-1:0]  index;
        word_sel_t                  word;
        logic [`LC_OFFSET_BITS-1:0] offset;
    } load_addr_t;

    // Word address seen by the cache arrays, byte offset dropped
    typedef struct packed {
        logic [`LC_TAG_BITS-1:0]   tag;
        logic [`LC_INDEX_BITS-1:0] index;
        word_sel_t                 word;
    } cache_addr_t;

    // Field enables, status covers valid and dirty together
    typedef struct packed {
        logic tag;
        logic status;
        logic data;
    } cache_enable_t;

    // Read port request
    typedef struct packed {
        logic          read;
        cache_enable_t enable;
        cache_addr_t   addr;
    } cache_read_t;

    // Write port request
    typedef struct packed {
        logic          write;
        cache_enable_t enable;
        cache_addr_t   addr;
        word_t         data;
    } cache_write_t;

    // One refill word from memory with its position in the line
    typedef struct packed {
        logic         valid;
        word_onehot_t word;
        word_t        data;
    } mem_word_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE_TAG,
        DATA_STABLE,
        MEMORY_REQUEST,
        ALLOCATE
    } lc_state_t;

endpackage

`default_nettype wire

/* hw/victim_way_lfsr.sv */
// Pseudo-random victim way select for refills, held steady while a line is being replaced
`default_nettype none

module victim_way_lfsr (
    input  wire                                clk_i,
    input  wire                                rst_n_i,
    // High for the whole refill so the way cannot move under the allocator
    input  wire                                freeze_i,
    output load_cache_pkg::way_onehot_t        way_o
);

    logic [2:0] lfsr_q;
    logic       feedback;

    // XNOR feedback, so the all-ones pattern is the locked state and never reached from 3'b010
    assign feedback = ~(lfsr_q[2] ^ lfsr_q[1]);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= 3'b010;
        end else if (!freeze_i) begin
            lfsr_q <= {lfsr_q[1:0], feedback};
        end
    end

    // Low two bits pick one of the four ways
    assign way_o = load_cache_pkg::way_onehot_t'(1) << lfsr_q[1:0];

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/load_cache_pkg.sv
hw/line_fill_buffer.sv
hw/victim_way_lfsr.sv
hw/load_cache_fsm.sv
hw/load_cache_ctrl.sv
verif/load_cache_ctrl_tb.sv

/* verif/load_cache_ctrl_tb.sv */
// Table-driven testbench for the load cache controller, run as the simulation top with the RTL
`default_nettype none

`include "load_cache_params.svh"

module load_cache_ctrl_tb;

    localparam int period    = 100;
    localparam int num_rows  = 12;
    localparam int ack_delay = 2;

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        K_STORE_UNIT,
        K_STORE_BUF,
        K_HIT,
        K_MISS
    } case_kind_t;

    // Gap is the base spacing between memory words and each word adds one random cycle
    typedef struct packed {
        case_kind_t                 kind;
        load_cache_pkg::load_addr_t load_addr;
        load_cache_pkg::load_addr_t su_addr;
        logic                       su_idle;
        logic                       sb_match;
        logic [3:0]                 gap;
        logic [3:0]                 grant_off;
    } row_t;

    row_t rows [num_rows] = '{
        '{K_STORE_UNIT, 32'h0040_1a24, 32'h0040_1a24, 1'b0, 1'b1, 4'd0, 4'd0},
        '{K_STORE_UNIT, 32'h0040_1a28, 32'h0040_1a28, 1'b0, 1'b0, 4'd0, 4'd0},
        '{K_STORE_BUF,  32'h0040_1a28, 32'h0040_1a28, 1'b1, 1'b1, 4'd0, 4'd0},
        '{K_STORE_BUF,  32'h0077_3300, 32'h0077_3304, 1'b0, 1'b1, 4'd0, 4'd0},
        '{K_HIT,        32'h0012_0a1c, 32'h0012_0a18, 1'b0, 1'b0, 4'd0, 4'd0},
        '{K_MISS,       32'h0a5c_3e08, 32'h0000_0000, 1'b1, 1'b0, 4'd0, 4'd0},
        '{K_MISS,       32'h0a5c_3f00, 32'h0a5c_3f04, 1'b0, 1'b0, 4'd2, 4'd3},
        '{K_MISS,       32'h3ff0_004c, 32'h3ff0_0040, 1'b0, 1'b0, 4'd1, 4'd0},
        '{K_HIT,        32'h3ff0_004c, 32'h3ff0_004c, 1'b1, 1'b0, 4'd0, 4'd0},
        '{K_MISS,       32'h0001_2344, 32'h0001_2340, 1'b0, 1'b0, 4'd0, 4'd6},
        '{K_STORE_UNIT, 32'h0001_2344, 32'h0001_2344, 1'b0, 1'b1, 4'd0, 4'd0},
        '{K_MISS,       32'hdead_bef0, 32'hdead_bef4, 1'b0, 1'b0, 4'd3, 4'd1}
    };

    // ----------------------------------------------------------
    // DUT signals
    // ----------------------------------------------------------
    logic                          clk_i;
    logic                          rst_n_i;
    logic                          load_read_i;
    load_cache_pkg::load_addr_t    load_addr_i;
    load_cache_pkg::load_addr_t    store_unit_addr_i;
    load_cache_pkg::word_t         store_unit_data_i;
    logic                          store_unit_idle_i;
    logic                          store_buffer_match_i;
    load_cache_pkg::word_t         store_buffer_data_i;
    logic                          cache_hit_i;
    load_cache_pkg::word_t         cache_data_i;
    logic                          cache_grant_i;
    logic                          mem_ack_i;
    load_cache_pkg::mem_word_t     mem_word_i;
    load_cache_pkg::cache_read_t   cache_read_o;
    load_cache_pkg::cache_write_t  cache_write_o;
    load_cache_pkg::way_onehot_t   cache_way_o;
    logic                          mem_request_o;
    logic                          write_port_request_o;
    logic                          stall_o;
    load_cache_pkg::word_t         data_o;
    logic                          data_valid_o;
    logic                          done_o;

    load_cache_ctrl dut0 (.*);

    // ----------------------------------------------------------
    // Testbench state
    // ----------------------------------------------------------
    logic [31:0]                  lfsr_state = 32'h6211cd3f;
    int                           error_count;
    int                           check_count;
    row_t                         cur;
    logic                         row_active;
    logic                         rst_stage;
    logic                         read_stage;
    int                           cyc;
    load_cache_pkg::word_t        su_data;
    load_cache_pkg::word_t        sb_data;
    load_cache_pkg::word_t        hit_data;
    load_cache_pkg::word_t        line_data [`LC_BLOCK_WORDS];
    load_cache_pkg::cache_addr_t  exp_addr;

    // The responders react to the outputs seen in the previous cycle
    logic                         obs_read;
    logic                         obs_mem_req;

    // Memory responder phase is 0 while waiting, 1 while counting to the ack, 2 while sending
    int                           mem_phase;
    int                           mem_delay;
    int                           mem_idx;
    int                           mem_gap;
    int                           grant_left;

    // Per row observations
    int                           ack_cyc;
    int                           valid_count;
    int                           valid_cyc;
    load_cache_pkg::word_t        valid_data;
    int                           done_cyc;
    load_cache_pkg::way_onehot_t  refill_way;
    load_cache_pkg::cache_write_t writes [$];

    initial begin
        clk_i = 1'b0;
        forever begin
            #(period / 2) clk_i = ~clk_i;
        end
    end

    // Galois LFSR that steps once per random bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check(input logic cond, input string msg);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("** Error at time %0t: %s", $time, msg);
        end
    endtask

    // ----------------------------------------------------------
    // Responders
    // ----------------------------------------------------------

    // Cache answers a read one cycle after the strobe
    task automatic drive_cache();
        cache_hit_i  = obs_read && (cur.kind == K_HIT);
        cache_data_i = hit_data;
    endtask

    task automatic drive_memory();
        mem_ack_i  = 1'b0;
        mem_word_i = '0;
        if (mem_phase == 0) begin
            if (obs_mem_req) begin
                mem_phase = 1;
                mem_delay = ack_delay;
            end
        end else if (mem_phase == 1) begin
            if (mem_delay == 0) begin
                mem_ack_i  = 1'b1;
                ack_cyc    = cyc;
                grant_left = int'(cur.grant_off);
                mem_phase  = 2;
                mem_idx    = 0;
                mem_gap    = int'(cur.gap) + int'(rand_bits(1));
            end else begin
                mem_delay--;
            end
        end else if (mem_gap > 0) begin
            mem_gap--;
        end else begin
            // Words leave in line order with their one-hot markers
            mem_word_i.valid = 1'b1;
            mem_word_i.word  = load_cache_pkg::word_onehot_t'(1) << mem_idx;
            mem_word_i.data  = line_data[mem_idx];
            mem_idx++;
            mem_gap = int'(cur.gap) + int'(rand_bits(1));
            if (mem_idx == `LC_BLOCK_WORDS) begin
                mem_phase = 0;
            end
        end
        // Grant drops from the ack for the row's grant-off cycles
        cache_grant_i = (grant_left == 0);
        if (grant_left > 0) begin
            grant_left--;
        end
    endtask

    // ----------------------------------------------------------
    // Per cycle drive and observation
    // ----------------------------------------------------------
    task automatic observe();
        logic exp_stall;
        logic exp_mreq;
        logic exp_wreq;
        exp_stall   = (cur.kind == K_MISS) && (cyc >= 1);
        exp_mreq    = (cur.kind == K_MISS) && (cyc >= 2) && (ack_cyc < 0 || cyc <= ack_cyc);
        exp_wreq    = (cur.kind == K_MISS) && (ack_cyc >= 0) && (cyc > ack_cyc);
        obs_read    = cache_read_o.read;
        obs_mem_req = mem_request_o;
        check($onehot(cache_way_o), $sformatf("cache_way_o %b is not one-hot", cache_way_o));
        if (!row_active) begin
            return;
        end
        check(cache_read_o.read == (cyc == 0), $sformatf("read strobe %b in cycle %0d",
              cache_read_o.read, cyc));
        if (cache_read_o.read) begin
            check(cache_read_o.addr == exp_addr && cache_read_o.enable == 3'b111,
                  $sformatf("lookup addr %h enable %b", cache_read_o.addr, cache_read_o.enable));
        end
        check(!(cache_write_o.write && !cache_grant_i), "write strobe while grant is low");
        if (cache_write_o.write) begin
            writes.push_back(cache_write_o);
        end
        check(stall_o == exp_stall, $sformatf("stall_o %b, expected %b", stall_o, exp_stall));
        check(mem_request_o == exp_mreq,
              $sformatf("mem_request_o %b, expected %b", mem_request_o, exp_mreq));
        // The write port is wanted from the cycle after the ack until the last write
        check(write_port_request_o == exp_wreq,
              $sformatf("write_port_request_o %b, expected %b", write_port_request_o, exp_wreq));
        // The victim way is taken once the memory request starts
        if (cur.kind == K_MISS && cyc == 2) begin
            refill_way = cache_way_o;
        end else if (cur.kind == K_MISS && cyc > 2) begin
            check(cache_way_o == refill_way,
                  $sformatf("way moved from %b to %b", refill_way, cache_way_o));
        end
        if (data_valid_o) begin
            valid_count++;
            valid_cyc  = cyc;
            valid_data = data_o;
            if (cur.kind == K_MISS) begin
                check(cache_write_o.write && cache_write_o.addr.word == cur.load_addr.word,
                      "data_valid_o is not on the requested word write");
            end
        end
        if (done_o) begin
            done_cyc = cyc;
            if (cur.kind == K_MISS) begin
                check(cache_write_o.write && cache_write_o.addr.word == 2'(`LC_BLOCK_WORDS - 1),
                      "done_o is not on the last word write");
            end
        end
    endtask

    // Inputs change only here just after the falling edge
    task automatic cycle();
        @(negedge clk_i);
        cyc++;
        rst_n_i              = rst_stage;
        load_read_i          = read_stage;
        read_stage           = 1'b0;
        load_addr_i          = cur.load_addr;
        store_unit_addr_i    = cur.su_addr;
        store_unit_idle_i    = cur.su_idle;
        store_unit_data_i    = su_data;
        store_buffer_match_i = cur.sb_match;
        store_buffer_data_i  = sb_data;
        drive_cache();
        drive_memory();
        #1;
        observe();
    endtask

    // ----------------------------------------------------------
    // Row execution and final compare
    // ----------------------------------------------------------
    task automatic run_row(input int idx);
        load_cache_pkg::cache_addr_t a;
        load_cache_pkg::word_t       exp_data;
        int                          exp_cyc;
        cur      = rows[idx];
        su_data  = rand_bits(32);
        sb_data  = rand_bits(32);
        hit_data = rand_bits(32);
        for (int w = 0; w < `LC_BLOCK_WORDS; w++) begin
            line_data[w] = rand_bits(32);
        end
        exp_addr    = {cur.load_addr.tag, cur.load_addr.index, cur.load_addr.word};
        ack_cyc     = -1;
        valid_count = 0;
        valid_cyc   = -1;
        done_cyc    = -1;
        writes.delete();
        read_stage  = 1'b1;
        row_active  = 1'b1;
        cyc         = -1;
        while (done_cyc < 0) begin
            cycle();
        end
        if (cur.kind == K_MISS) begin
            check(valid_count == 1 && valid_data == line_data[cur.load_addr.word],
                  $sformatf("row %0d: %0d valid pulses, data %h, expected %h", idx,
                  valid_count, valid_data, line_data[cur.load_addr.word]));
            check(writes.size() == `LC_BLOCK_WORDS,
                  $sformatf("row %0d: %0d writes in the refill", idx, writes.size()));
            for (int i = 0; i < writes.size(); i++) begin
                a      = exp_addr;
                a.word = 2'(i);
                check(writes[i].addr == a && writes[i].data == line_data[i] &&
                      writes[i].enable == ((i == 0) ? 3'b111 : 3'b001),
                      $sformatf("row %0d: write %0d addr %h data %h enable %b", idx, i,
                      writes[i].addr, writes[i].data, writes[i].enable));
            end
        end else begin
            exp_cyc  = (cur.kind == K_HIT) ? 2 : 1;
            exp_data = (cur.kind == K_STORE_UNIT) ? su_data :
                       (cur.kind == K_STORE_BUF) ? sb_data : hit_data;
            check(valid_count == 1 && valid_cyc == exp_cyc && done_cyc == exp_cyc,
                  $sformatf("row %0d: valid in cycle %0d, done in cycle %0d, expected %0d",
                  idx, valid_cyc, done_cyc, exp_cyc));
            check(valid_data == exp_data,
                  $sformatf("row %0d: data_o %h, expected %h", idx, valid_data, exp_data));
            check(writes.size() == 0, $sformatf("row %0d: unexpected cache write", idx));
        end
    endtask

    initial begin
        cur         = '0;
        row_active  = 1'b0;
        rst_stage   = 1'b0;
        read_stage  = 1'b0;
        obs_read    = 1'b0;
        obs_mem_req = 1'b0;
        su_data     = '0;
        sb_data     = '0;
        hit_data    = '0;
        rst_n_i              = 1'b0;
        load_read_i          = 1'b0;
        load_addr_i          = '0;
        store_unit_addr_i    = '0;
        store_unit_data_i    = '0;
        store_unit_idle_i    = 1'b1;
        store_buffer_match_i = 1'b0;
        store_buffer_data_i  = '0;
        cache_hit_i          = 1'b0;
        cache_data_i         = '0;
        cache_grant_i        = 1'b0;
        mem_ack_i            = 1'b0;
        mem_word_i           = '0;
        repeat (8) begin
            cycle();
        end
        rst_stage = 1'b1;
        cycle();
        check(!data_valid_o && !done_o && !mem_request_o && !write_port_request_o &&
              !stall_o && !cache_read_o.read && !cache_write_o.write,
              "strobe or level output active after reset");
        // The victim LFSR starts at 3'b010, which selects way 2
        check(cache_way_o == 4'b0100,
              $sformatf("cache_way_o %b after reset, expected 0100", cache_way_o));
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Each row gets 60 cycles and the reset gets nine more
    initial begin
        #((num_rows * 60 + 9) * period);
        $display("Watchdog timeout: the table did not complete in the allowed time");
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
